// ==== hdl/rvc_patterns.svh ====
// RVC match patterns
// casez patterns for the compressed instructions with register operands

`ifndef RVC_PATTERNS_SVH
`define RVC_PATTERNS_SVH

// ********************
// Quadrant 0
// ********************
`define C_ADDI4SPN 16'b000???????????00
`define C_LW       16'b010???????????00
`define C_SW       16'b110???????????00

// ********************
// Quadrant 1
// ********************
`define C_NOP      16'b000?00000?????01
`define C_ADDI     16'b000???????????01
`define C_JAL      16'b001???????????01
`define C_LI       16'b010???????????01
`define C_ADDI16SP 16'b011?00010?????01
`define C_SRLI     16'b100?00????????01
`define C_SRAI     16'b100?01????????01
`define C_ANDI     16'b100?10????????01
`define C_SUB      16'b100011???00???01
`define C_XOR      16'b100011???01???01
`define C_OR       16'b100011???10???01
`define C_AND      16'b100011???11???01
`define C_J        16'b101???????????01
`define C_BEQZ     16'b110???????????01
`define C_BNEZ     16'b111???????????01

// ********************
// Quadrant 2
// ********************
`define C_SLLI     16'b000???????????10
`define C_LWSP     16'b010???????????10
`define C_JR       16'b1000?????0000010
`define C_MV       16'b1000??????????10
`define C_EBREAK   16'b1001000000000010
`define C_JALR     16'b1001?????0000010
`define C_ADD      16'b1001??????????10
`define C_SWSP     16'b110???????????10

`endif

// ==== hdl/rv_defs_pkg.sv ====
// RV32 register-operand definitions
// Register types, fixed register numbers and the structs of the decode front

package rv_defs_pkg;

  // ********************
  // Widths and counts
  // ********************

  localparam int xlen       = 32;
  localparam int gpr_addr_w = 5;
  localparam int gpr_count  = 2 ** gpr_addr_w;

  typedef logic [gpr_addr_w-1:0] gpr_addr_t;
  typedef logic [xlen-1:0]       gpr_data_t;

  // ********************
  // Implied registers
  // ********************

  localparam gpr_addr_t reg_x0 = 5'd0;
  localparam gpr_addr_t reg_ra = 5'd1;
  localparam gpr_addr_t reg_sp = 5'd2;

  // Compressed 3-bit fields cover x8 to x15
  localparam logic [1:0] rvc_reg_base = 2'b01;

  function automatic gpr_addr_t rvc_reg(logic [2:0] field);
    return {rvc_reg_base, field};
  endfunction

  // ********************
  // Structs
  // ********************

  // Register addresses of one instruction, 16 bits
  typedef struct packed {
    gpr_addr_t rd;
    gpr_addr_t rs1;
    gpr_addr_t rs2;
    logic      compressed;
  } gpr_addrs_t;

  // Write-back port, 38 bits
  typedef struct packed {
    logic      en;
    gpr_addr_t addr;
    gpr_data_t data;
  } gpr_write_t;

  // Addresses plus operand values, 80 bits
  typedef struct packed {
    gpr_addrs_t addrs;
    gpr_data_t  rs1_data;
    gpr_data_t  rs2_data;
  } id_operands_t;

endpackage

// ==== hdl/stage_reg.sv ====
// Pipeline register
// Holds one payload with its valid bit

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  // Payload held while no item arrives
  always_ff @(posedge clk) begin
    if (valid_in) begin
      data_out <= data_in;
    end
  end

endmodule

// ==== hdl/rvc_gpr_decode.sv ====
// Compressed register decode
// Maps a 16-bit RVC word onto full rd, rs1 and rs2 addresses

`include "rvc_patterns.svh"

module rvc_gpr_decode (
  input  logic [15:0]             instr,
  output rv_defs_pkg::gpr_addrs_t addrs
);
  import rv_defs_pkg::*;

  gpr_addr_t rd_full;
  gpr_addr_t rs2_full;
  gpr_addr_t hi_prime;
  gpr_addr_t lo_prime;

  // Full fields at 11:7 and 6:2, short fields at 9:7 and 4:2
  assign rd_full  = instr[11:7];
  assign rs2_full = instr[6:2];
  assign hi_prime = rvc_reg(instr[9:7]);
  assign lo_prime = rvc_reg(instr[4:2]);

  always_comb begin
    addrs.rd         = rd_full;
    addrs.rs1        = reg_x0;
    addrs.rs2        = reg_x0;
    addrs.compressed = 1'b1;

    // Order matters where patterns overlap
    casez (instr)
      `C_ADDI4SPN: begin
        addrs.rd  = lo_prime;
        addrs.rs1 = reg_sp;
      end
      `C_LW: begin
        addrs.rd  = lo_prime;
        addrs.rs1 = hi_prime;
      end
      `C_SW: begin
        addrs.rs1 = hi_prime;
        addrs.rs2 = lo_prime;
      end
      `C_NOP: begin
        addrs.rd  = reg_x0;
        addrs.rs1 = reg_x0;
      end
      `C_ADDI: addrs.rs1 = rd_full;
      `C_JAL:  addrs.rd = reg_ra;
      `C_LI:   addrs.rs1 = reg_x0;
      `C_ADDI16SP: begin
        addrs.rd  = reg_sp;
        addrs.rs1 = reg_sp;
      end
      `C_SRLI, `C_SRAI, `C_ANDI: begin
        addrs.rd  = hi_prime;
        addrs.rs1 = hi_prime;
      end
      `C_SUB, `C_XOR, `C_OR, `C_AND: begin
        addrs.rd  = hi_prime;
        addrs.rs1 = hi_prime;
        addrs.rs2 = lo_prime;
      end
      `C_J: addrs.rd = reg_x0;
      `C_BEQZ, `C_BNEZ: begin
        addrs.rs1 = hi_prime;
        addrs.rs2 = reg_x0;
      end
      `C_SLLI: addrs.rs1 = rd_full;
      `C_LWSP: addrs.rs1 = reg_sp;
      `C_JR: begin
        addrs.rd  = reg_x0;
        addrs.rs1 = rd_full;
      end
      `C_MV: begin
        addrs.rs1 = reg_x0;
        addrs.rs2 = rs2_full;
      end
      `C_EBREAK: addrs.rd = reg_x0;
      `C_JALR: begin
        addrs.rd  = reg_ra;
        addrs.rs1 = rd_full;
      end
      `C_ADD: begin
        addrs.rs1 = rd_full;
        addrs.rs2 = rs2_full;
      end
      `C_SWSP: begin
        addrs.rs1 = reg_sp;
        addrs.rs2 = rs2_full;
      end
      // Unknown words keep rd from 11:7 and no sources
      default: addrs.rd = rd_full;
    endcase
  end

endmodule

// ==== hdl/gpr_addr_select.sv ====
// Register address select
// Picks compressed or 32-bit register fields for one instruction word

module gpr_addr_select (
  input  logic [31:0]             instr,
  output rv_defs_pkg::gpr_addrs_t addrs
);
  import rv_defs_pkg::*;

  logic       is_compressed;
  gpr_addrs_t rvc_addrs;
  gpr_addrs_t full_addrs;

  // Anything but 2'b11 in the low bits is a 16-bit word
  assign is_compressed = (instr[1:0] != 2'b11);

  rvc_gpr_decode rvc_gpr_decode_inst (
    .instr (instr[15:0]),
    .addrs (rvc_addrs)
  );

  // ********************
  // 32-bit fields
  // ********************

  always_comb begin
    full_addrs.rd         = instr[11:7];
    full_addrs.rs1        = instr[19:15];
    full_addrs.rs2        = instr[24:20];
    full_addrs.compressed = 1'b0;
  end

  assign addrs = is_compressed ? rvc_addrs : full_addrs;

endmodule

// ==== hdl/gpr_file.sv ====
// General register file
// 32 x 32 bits, two combinational reads, one write, x0 reads zero

module gpr_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_defs_pkg::gpr_write_t wb,
  input  rv_defs_pkg::gpr_addr_t  rs1_addr,
  input  rv_defs_pkg::gpr_addr_t  rs2_addr,
  output rv_defs_pkg::gpr_data_t  rs1_data,
  output rv_defs_pkg::gpr_data_t  rs2_data
);
  import rv_defs_pkg::*;

  // x0 has no storage
  gpr_data_t regs [1:gpr_count-1];
  logic      wr_active;

  assign wr_active = wb.en && (wb.addr != reg_x0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 1; r < gpr_count; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_active) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // ********************
  // Read ports
  // ********************

  // Same-cycle write wins over the stored value
  function automatic gpr_data_t read_port(gpr_addr_t addr, gpr_write_t wr,
                                          gpr_data_t stored);
    if (addr == reg_x0) begin
      return '0;
    end
    if (wr.en && (wr.addr == addr)) begin
      return wr.data;
    end
    return stored;
  endfunction

  assign rs1_data = read_port(rs1_addr, wb, regs[rs1_addr]);
  assign rs2_data = read_port(rs2_addr, wb, regs[rs2_addr]);

endmodule

// ==== hdl/id_operand_stage.sv ====
// Decode operand front
// Register addresses and operand read for RV32IC words with a two-cycle latency

module id_operand_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_valid,
  input  logic [31:0]               instr,
  input  rv_defs_pkg::gpr_write_t   wb,
  output logic                      out_valid,
  output rv_defs_pkg::id_operands_t out_ops
);
  import rv_defs_pkg::*;

  gpr_addrs_t   dec_addrs;
  logic         s1_valid;
  gpr_addrs_t   s1_addrs;
  id_operands_t s2_in;

  // ********************
  // Decode in cycle 0
  // ********************

  gpr_addr_select gpr_addr_select_inst (
    .instr (instr),
    .addrs (dec_addrs)
  );

  stage_reg #(
    .payload_t (gpr_addrs_t)
  ) addr_reg_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (instr_valid),
    .data_in   (dec_addrs),
    .valid_out (s1_valid),
    .data_out  (s1_addrs)
  );

  // ********************
  // Operand read in cycle 1
  // ********************

  gpr_file gpr_file_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb       (wb),
    .rs1_addr (s1_addrs.rs1),
    .rs2_addr (s1_addrs.rs2),
    .rs1_data (s2_in.rs1_data),
    .rs2_data (s2_in.rs2_data)
  );

  assign s2_in.addrs = s1_addrs;

  stage_reg #(
    .payload_t (id_operands_t)
  ) ops_reg_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (s1_valid),
    .data_in   (s2_in),
    .valid_out (out_valid),
    .data_out  (out_ops)
  );

endmodule

// ==== bench/id_operand_stage_properties.sv ====
// Decode operand front assertions
// Reset, fixed two-cycle latency and x0 operand values

module id_operand_stage_properties (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      instr_valid,
  input logic                      out_valid,
  input rv_defs_pkg::id_operands_t out_ops
);
  import rv_defs_pkg::*;

  // Any reset edge leaves the output idle
  a_idle_in_reset: assert property (
    @(posedge clk) !rst_n |=> !out_valid
  ) else $error("out_valid high after a reset edge");

  // ********************
  // Streaming
  // ********************

  a_two_cycle_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid == $past(instr_valid, 2)
  ) else $error("out_valid does not follow instr_valid two cycles later");

  // x0 never carries data
  a_rs1_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && out_ops.addrs.rs1 == reg_x0) |-> out_ops.rs1_data == '0
  ) else $error("rs1_data nonzero for x0");

  a_rs2_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && out_ops.addrs.rs2 == reg_x0) |-> out_ops.rs2_data == '0
  ) else $error("rs2_data nonzero for x0");

endmodule

// ==== bench/id_operand_stage_tb.sv ====
// Testbench for the decode operand front
// Preloads the register file, streams an instruction table and checks each result

module id_operand_stage_tb;
  import rv_defs_pkg::*;

  localparam int reset_cycles   = 10;
  localparam int preload_len    = gpr_count - 1;
  localparam int table_len      = 30;
  localparam int timeout_cycles = preload_len + table_len + 50;

  typedef struct packed {
    logic        valid;
    logic [31:0] word;
    gpr_addrs_t  exp_addrs;
    gpr_write_t  wr;
  } row_t;

  typedef struct packed {
    logic         valid;
    id_operands_t ops;
  } expect_t;

  logic         clk;
  logic         rst_n;
  logic         instr_valid;
  logic [31:0]  instr;
  gpr_write_t   wb;
  logic         out_valid;
  id_operands_t out_ops;

  row_t      rows [table_len];
  gpr_data_t model [gpr_count];
  expect_t   exp_q [$];
  expect_t   idle_exp = '0;
  int        n_rows = 0;
  int        cycle_count = 0;

  id_operand_stage id_operand_stage_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb),
    .out_valid   (out_valid),
    .out_ops     (out_ops)
  );

  bind id_operand_stage id_operand_stage_properties props_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .out_valid   (out_valid),
    .out_ops     (out_ops)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ********************
  // Checks
  // ********************

  task automatic abort_run(string what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped on %s", what);
  endtask

  task automatic check_addrs(string name, gpr_addrs_t got, gpr_addrs_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run(name);
    end
  endtask

  task automatic check_data(string name, gpr_data_t got, gpr_data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run(name);
    end
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] out_valid: got 0x%h, expected 0x%h", got, exp);
      abort_run("out_valid");
    end
  endtask

  task automatic check_output(expect_t e);
    check_valid(out_valid, e.valid);
    if (e.valid) begin
      check_addrs("out_ops.addrs", out_ops.addrs, e.ops.addrs);
      check_data("out_ops.rs1_data", out_ops.rs1_data, e.ops.rs1_data);
      check_data("out_ops.rs2_data", out_ops.rs2_data, e.ops.rs2_data);
    end
  endtask

  // ********************
  // Reference model
  // ********************

  // x0 reads zero and a same-cycle write is seen by the read
  function automatic gpr_data_t model_read(gpr_addr_t addr, gpr_write_t wr);
    gpr_data_t value;
    value = model[addr];
    if (wr.en && wr.addr == addr) value = wr.data;
    if (addr == reg_x0) value = '0;
    return value;
  endfunction

  function automatic expect_t expect_for(row_t r);
    expect_t e;
    e.valid         = r.valid;
    e.ops.addrs     = r.exp_addrs;
    e.ops.rs1_data  = model_read(r.exp_addrs.rs1, r.wr);
    e.ops.rs2_data  = model_read(r.exp_addrs.rs2, r.wr);
    return e;
  endfunction

  task automatic update_model(gpr_write_t wr);
    if (wr.en && wr.addr != reg_x0) model[wr.addr] = wr.data;
  endtask

  function automatic gpr_write_t write_of(int addr, gpr_data_t data);
    gpr_write_t w;
    w.en   = 1'b1;
    w.addr = gpr_addr_t'(addr);
    w.data = data;
    return w;
  endfunction

  // ********************
  // Instruction table
  // ********************

  task automatic add_row(logic [31:0] word, int rd, int rs1, int rs2, logic c,
                         gpr_write_t wr);
    row_t r;
    r.valid                = 1'b1;
    r.word                 = word;
    r.exp_addrs.rd         = gpr_addr_t'(rd);
    r.exp_addrs.rs1        = gpr_addr_t'(rs1);
    r.exp_addrs.rs2        = gpr_addr_t'(rs2);
    r.exp_addrs.compressed = c;
    r.wr                   = wr;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_gap(gpr_write_t wr);
    row_t r;
    r      = '0;
    r.word = 32'h0000_0013;
    r.wr   = wr;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    // 32-bit R, I, S, B, R
    add_row(32'h0073_02B3, 5, 6, 7, 1'b0, '0);
    add_row(32'h1235_8513, 10, 11, 3, 1'b0, '0);
    add_row(32'h00C1_2423, 8, 2, 12, 1'b0, '0);
    add_row(32'h01F0_8063, 0, 1, 31, 1'b0, write_of(1, 32'h1357_9BDF));
    add_row(32'h41DF_0FB3, 31, 30, 29, 1'b0, '0);
    // Compressed quadrant 0 with junk in the upper half of c.lw
    add_row(32'hFFFF_4144, 9, 10, 0, 1'b1, '0);
    add_row(32'h0000_C380, 7, 15, 8, 1'b1, '0);
    add_row(32'h0000_002C, 11, 2, 0, 1'b1, '0);
    add_row(32'h0000_0001, 0, 0, 0, 1'b1, '0);
    add_gap(write_of(9, 32'h900D_CAFE));
    // Quadrant 1
    add_row(32'h0000_028D, 5, 5, 0, 1'b1, '0);
    add_row(32'h0000_2015, 1, 0, 0, 1'b1, '0);
    add_row(32'h0000_4705, 14, 0, 0, 1'b1, '0);
    add_row(32'h0000_6141, 2, 2, 0, 1'b1, '0);
    add_row(32'h0000_8005, 8, 8, 0, 1'b1, '0);
    add_row(32'h0000_8A95, 13, 13, 0, 1'b1, '0);
    add_row(32'h0000_8C89, 9, 9, 10, 1'b1, '0);
    add_row(32'h0000_8FE1, 15, 15, 8, 1'b1, '0);
    add_gap('0);
    add_row(32'h0000_A001, 0, 0, 0, 1'b1, '0);
    add_row(32'h0000_C201, 4, 12, 0, 1'b1, '0);
    // Quadrant 2
    add_row(32'h0000_0A0A, 20, 20, 0, 1'b1, '0);
    add_row(32'h0000_4382, 7, 2, 0, 1'b1, '0);
    add_row(32'h0000_8302, 0, 6, 0, 1'b1, '0);
    add_row(32'h0000_81C6, 3, 0, 17, 1'b1, write_of(0, 32'hDEAD_BEEF));
    add_row(32'h0000_9002, 0, 0, 0, 1'b1, '0);
    add_row(32'h0000_9482, 1, 9, 0, 1'b1, '0);
    add_row(32'h0000_9ADA, 21, 21, 22, 1'b1, write_of(22, 32'h0BAD_F00D));
    add_row(32'h001B_0233, 4, 22, 1, 1'b0, '0);
    add_row(32'h0000_C07A, 0, 2, 30, 1'b1, '0);
  endtask

  // Drive on the rising edge and check the result due at the falling edge
  task automatic step(logic valid, logic [31:0] word, gpr_write_t wr, expect_t e);
    @(posedge clk);
    instr_valid <= valid;
    instr       <= word;
    wb          <= wr;
    exp_q.push_back(e);
    @(negedge clk);
    check_output(exp_q.pop_front());
  endtask

  // ********************
  // Main sequence
  // ********************

  initial begin : main
    row_t       cur;
    gpr_write_t prev_wr;
    expect_t    e;
    void'($urandom(32'h1da19232));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    wb          = '0;
    model[0]    = '0;
    build_table();

    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      if (i == reset_cycles - 1) rst_n <= 1'b1;
      @(negedge clk);
      check_valid(out_valid, 1'b0);
    end

    // Two cycles of nothing in flight
    exp_q.push_back(idle_exp);
    exp_q.push_back(idle_exp);

    for (int r = 1; r < gpr_count; r++) begin
      model[r] = $urandom();
      step(1'b0, 32'h0, write_of(r, model[r]), idle_exp);
    end

    // Each row's write-back lands in the cycle its operands are read
    for (int i = 0; i <= table_len; i++) begin
      if (i < table_len) cur = rows[i];
      else cur = '0;
      if (i > 0) prev_wr = rows[i-1].wr;
      else prev_wr = '0;
      e = expect_for(cur);
      update_model(cur.wr);
      step(cur.valid, cur.word, prev_wr, e);
    end
    step(1'b0, 32'h0, '0, idle_exp);
    step(1'b0, 32'h0, '0, idle_exp);

    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin : watchdog
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > timeout_cycles) begin
        $display("Run did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout");
      end
    end
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/rv_defs_pkg.sv
hdl/stage_reg.sv
hdl/rvc_gpr_decode.sv
hdl/gpr_addr_select.sv
hdl/gpr_file.sv
hdl/id_operand_stage.sv
bench/id_operand_stage_properties.sv
bench/id_operand_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the id_operand_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module id_operand_stage_tb -f project.f -o sim_top

./obj_dir/sim_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi
echo "Simulation passed"
